// File: rtl/armIsaPkg.sv
package armIsaPkg;

  typedef logic [2:0] aluCtrlT;
  typedef logic [3:0] condT;
  typedef logic [3:0] flagsT;

  // Instruction field positions
  localparam int condMsb = 31;
  localparam int condLsb = 28;
  localparam int classMsb = 27;
  localparam int classLsb = 26;
  localparam int immBit = 25;
  localparam int opcodeMsb = 24;
  localparam int opcodeLsb = 21;
  localparam int loadBit = 20;
  localparam int rnMsb = 19;
  localparam int rnLsb = 16;
  localparam int rdMsb = 15;
  localparam int rdLsb = 12;
  localparam int rmMsb = 3;
  localparam int rmLsb = 0;
  localparam int imm8Msb = 7;
  localparam int imm12Msb = 11;
  localparam int imm24Msb = 23;

  // Flag bit positions inside flagsT
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  localparam condT condEq = 4'b0000;
  localparam condT condNe = 4'b0001;
  localparam condT condGe = 4'b1010;
  localparam condT condLt = 4'b1011;
  localparam condT condAl = 4'b1110;

  localparam logic [3:0] opAnd = 4'b0000;
  localparam logic [3:0] opSub = 4'b0010;
  localparam logic [3:0] opAdd = 4'b0100;
  localparam logic [3:0] opCmp = 4'b1010;
  localparam logic [3:0] opOrr = 4'b1100;
  localparam logic [3:0] opMov = 4'b1101;

  localparam logic [1:0] classData = 2'b00;
  localparam logic [1:0] classMem = 2'b01;
  localparam logic [1:0] classBranch = 2'b10;

  localparam aluCtrlT aluAdd = 3'd0;
  localparam aluCtrlT aluSub = 3'd1;
  localparam aluCtrlT aluAnd = 3'd2;
  localparam aluCtrlT aluOrr = 3'd3;
  localparam aluCtrlT aluPassB = 3'd4;

  // MOV r0, r0 decodes as a pure bubble
  localparam logic [31:0] nopInstr = 32'he1a0_0000;

endpackage

// File: rtl/armPipePkg.sv
package armPipePkg;

  localparam int dataWidth = 32;
  localparam int regAddrWidth = 4;

  // R15 is not part of the register file
  localparam int regCount = 15;

  typedef logic [regAddrWidth-1:0] regAddrT;
  typedef logic [dataWidth-1:0] wordT;

  localparam wordT resetPc = '0;
  localparam wordT pcStep = 32'd4;
  localparam wordT pcAhead = 32'd8;

  // Instructions behind a taken branch that get squashed
  localparam int branchPenalty = 2;

endpackage

// File: rtl/fetchStage.sv
`timescale 1ns/100ps

module fetchStage
  import armPipePkg::*;
  import armIsaPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  wordT instruction,
  input  logic branchTaken,
  input  wordT branchTarget,
  output wordT pc,
  output wordT instrD,
  output wordT pcPlus8D
);

  wordT pcNext;

  // Redirect wins over sequential fetch
  assign pcNext = branchTaken ? branchTarget : pc + pcStep;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= resetPc;
    end else begin
      pc <= pcNext;
    end
  end

  // IF/ID instruction, squashed to a NOP behind a taken branch
  always_ff @(posedge clk) begin
    if (rst || branchTaken) begin
      instrD <= nopInstr;
    end else begin
      instrD <= instruction;
    end
  end

  // Architectural PC value seen by the instruction in decode
  always_ff @(posedge clk) begin
    pcPlus8D <= pc + pcAhead;
  end

  // Targets come from execute, so alignment depends on the offset scaling there
  pcAligned: assert property (
    @(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00
  ) else $error("fetch: misaligned pc %h", pc);

endmodule

// File: rtl/decodeStage.sv
`timescale 1ns/100ps

module decodeStage
  import armPipePkg::*;
  import armIsaPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wordT    instrD,
  input  wordT    pcPlus8D,
  input  logic    branchTaken,
  input  wordT    resultW,
  input  regAddrT waW,
  input  logic    regWriteW,
  output wordT    rd1E,
  output wordT    rd2E,
  output wordT    immE,
  output regAddrT waE,
  output aluCtrlT aluCtrlE,
  output condT    condE,
  output logic    aluSrcE,
  output logic    regWriteE,
  output logic    memWriteE,
  output logic    memToRegE,
  output logic    flagWriteE,
  output logic    branchE
);

  wordT regFile [regCount];

  logic [1:0] opClass;
  logic [3:0] opcode;
  regAddrT ra1, ra2, rdField;
  wordT rd1Reg, rd2Reg, rd1D, immD;
  aluCtrlT aluCtrlD;
  logic aluSrcD, regWriteD, memWriteD, memToRegD, flagWriteD, branchD;

  assign opClass = instrD[classMsb:classLsb];
  assign opcode = instrD[opcodeMsb:opcodeLsb];
  assign rdField = instrD[rdMsb:rdLsb];
  assign ra1 = instrD[rnMsb:rnLsb];
  // Stores read their data register through the second port
  assign ra2 = (opClass == classMem) ? rdField : instrD[rmMsb:rmLsb];

  always_ff @(posedge clk) begin
    if (regWriteW) begin
      regFile[waW] <= resultW;
    end
  end

  // Write-through from writeback in the same cycle
  assign rd1Reg = (regWriteW && waW == ra1) ? resultW : regFile[ra1];
  assign rd2Reg = (regWriteW && waW == ra2) ? resultW : regFile[ra2];

  // Branch target is formed in the ALU from PC+8
  assign rd1D = branchD ? pcPlus8D : rd1Reg;

  always_comb begin
    aluCtrlD = aluAdd;
    aluSrcD = 1'b0;
    regWriteD = 1'b0;
    memWriteD = 1'b0;
    memToRegD = 1'b0;
    flagWriteD = 1'b0;
    branchD = 1'b0;
    case (opClass)
      classData: begin
        aluSrcD = instrD[immBit];
        regWriteD = 1'b1;
        case (opcode)
          opAdd: aluCtrlD = aluAdd;
          opSub: aluCtrlD = aluSub;
          opAnd: aluCtrlD = aluAnd;
          opOrr: aluCtrlD = aluOrr;
          opMov: aluCtrlD = aluPassB;
          opCmp: begin
            aluCtrlD = aluSub;
            regWriteD = 1'b0;
            flagWriteD = 1'b1;
          end
          default: regWriteD = 1'b0;
        endcase
      end
      classMem: begin
        aluSrcD = 1'b1;
        if (instrD[loadBit]) begin
          regWriteD = 1'b1;
          memToRegD = 1'b1;
        end else begin
          memWriteD = 1'b1;
        end
      end
      classBranch: begin
        aluSrcD = 1'b1;
        branchD = 1'b1;
      end
      default: ;
    endcase
    // R15 is never a destination
    if (rdField == 4'd15) begin
      regWriteD = 1'b0;
    end
    if (instrD == nopInstr) begin
      regWriteD = 1'b0;
      memWriteD = 1'b0;
      memToRegD = 1'b0;
      flagWriteD = 1'b0;
      branchD = 1'b0;
    end
  end

  always_comb begin
    case (opClass)
      classMem: immD = {20'b0, instrD[imm12Msb:0]};
      // Word offset scaled to bytes
      classBranch: immD = {{6{instrD[imm24Msb]}}, instrD[imm24Msb:0], 2'b00};
      default: immD = {24'b0, instrD[imm8Msb:0]};
    endcase
  end

  // ID/EX control, bubbled behind a taken branch
  always_ff @(posedge clk) begin
    if (rst || branchTaken) begin
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      flagWriteE <= 1'b0;
      branchE <= 1'b0;
    end else begin
      regWriteE <= regWriteD;
      memWriteE <= memWriteD;
      memToRegE <= memToRegD;
      flagWriteE <= flagWriteD;
      branchE <= branchD;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    rd1E <= rd1D;
    rd2E <= rd2Reg;
    immE <= immD;
    waE <= rdField;
    aluCtrlE <= aluCtrlD;
    aluSrcE <= aluSrcD;
    condE <= instrD[condMsb:condLsb];
  end

  // Destination filtering here must hold all the way to writeback
  noPcWrite: assert property (
    @(posedge clk) disable iff (rst)
    regWriteW |-> waW != 4'd15
  ) else $error("decode: writeback targets r15");

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/100ps

module executeStage
  import armPipePkg::*;
  import armIsaPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wordT    rd1E,
  input  wordT    rd2E,
  input  wordT    immE,
  input  regAddrT waE,
  input  aluCtrlT aluCtrlE,
  input  logic    aluSrcE,
  input  logic    regWriteE,
  input  logic    memWriteE,
  input  logic    memToRegE,
  input  logic    flagWriteE,
  input  logic    branchE,
  input  condT    condE,
  output logic    branchTaken,
  output wordT    branchTarget,
  output wordT    aluOutM,
  output wordT    writeDataM,
  output regAddrT waM,
  output logic    regWriteM,
  output logic    memWriteM,
  output logic    memToRegM
);

  wordT srcB, bOperand, aluResult;
  logic [dataWidth:0] sum;
  logic isSub;
  flagsT flags, aluFlags;
  logic condPass;

  assign srcB = aluSrcE ? immE : rd2E;
  assign isSub = (aluCtrlE == aluSub);

  // Subtract as a + ~b + 1 so carry means no borrow
  assign bOperand = isSub ? ~srcB : srcB;
  assign sum = {1'b0, rd1E} + {1'b0, bOperand} + {{dataWidth{1'b0}}, isSub};

  always_comb begin
    case (aluCtrlE)
      aluAdd, aluSub: aluResult = sum[dataWidth-1:0];
      aluAnd: aluResult = rd1E & srcB;
      aluOrr: aluResult = rd1E | srcB;
      aluPassB: aluResult = srcB;
      default: aluResult = '0;
    endcase
  end

  always_comb begin
    aluFlags[flagN] = aluResult[dataWidth-1];
    aluFlags[flagZ] = (aluResult == '0);
    aluFlags[flagC] = sum[dataWidth];
    // Signed overflow when operand signs agree but the result's differs
    aluFlags[flagV] = (rd1E[dataWidth-1] == bOperand[dataWidth-1])
                      && (sum[dataWidth-1] != rd1E[dataWidth-1]);
  end

  always_comb begin
    case (condE)
      condEq: condPass = flags[flagZ];
      condNe: condPass = !flags[flagZ];
      condGe: condPass = (flags[flagN] == flags[flagV]);
      condLt: condPass = (flags[flagN] != flags[flagV]);
      condAl: condPass = 1'b1;
      default: condPass = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (flagWriteE && condPass) begin
      flags <= aluFlags;
    end
  end

  assign branchTaken = branchE && condPass;
  assign branchTarget = aluResult;

  // EX/MEM control, dropped when the condition fails
  always_ff @(posedge clk) begin
    if (rst) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
    end else begin
      regWriteM <= regWriteE && condPass;
      memWriteM <= memWriteE && condPass;
      memToRegM <= memToRegE && condPass;
    end
  end

  always_ff @(posedge clk) begin
    aluOutM <= aluResult;
    writeDataM <= rd2E;
    waM <= waE;
  end

  // The flushed slots reach execute as bubbles and cannot redirect again
  branchFlush: assert property (
    @(posedge clk) disable iff (rst)
    branchTaken |-> branchE ##1 (!branchTaken) [*branchPenalty]
  ) else $error("execute: redirect from a flushed slot");

endmodule

// File: rtl/memoryStage.sv
`timescale 1ns/100ps

module memoryStage
  import armPipePkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wordT    aluOutM,
  input  wordT    writeDataM,
  input  regAddrT waM,
  input  logic    regWriteM,
  input  logic    memWriteM,
  input  logic    memToRegM,
  input  wordT    readData,
  output wordT    dataAddr,
  output wordT    writeData,
  output logic    memWrite,
  output wordT    resultW,
  output regAddrT waW,
  output logic    regWriteW
);

  wordT readDataW, aluOutW;
  logic memToRegW;

  // Data memory answers in the same cycle
  assign dataAddr = aluOutM;
  assign writeData = writeDataM;
  assign memWrite = memWriteM;

  always_ff @(posedge clk) begin
    if (rst) begin
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
    end else begin
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
    end
  end

  always_ff @(posedge clk) begin
    readDataW <= readData;
    aluOutW <= aluOutM;
    waW <= waM;
  end

  // Load data or ALU result back to the register file
  assign resultW = memToRegW ? readDataW : aluOutW;

  // Store strobe is built from control in every earlier stage
  memWriteKnown: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(memWrite)
  ) else $error("memory: memWrite is unknown");

endmodule

// File: rtl/armCore.sv
`timescale 1ns/100ps

module armCore
  import armPipePkg::*;
  import armIsaPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  wordT instruction,
  input  wordT readData,
  output wordT pc,
  output wordT dataAddr,
  output wordT writeData,
  output logic memWrite
);

  wordT instrD, pcPlus8D;
  wordT rd1E, rd2E, immE;
  regAddrT waE, waM, waW;
  aluCtrlT aluCtrlE;
  condT condE;
  logic aluSrcE, regWriteE, memWriteE, memToRegE, flagWriteE, branchE;
  logic branchTaken;
  wordT branchTarget;
  wordT aluOutM, writeDataM;
  logic regWriteM, memWriteM, memToRegM;
  wordT resultW;
  logic regWriteW;

  fetchStage stageFetch (
    .clk(clk),
    .rst(rst),
    .instruction(instruction),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .pc(pc),
    .instrD(instrD),
    .pcPlus8D(pcPlus8D)
  );

  decodeStage stageDecode (
    .clk(clk),
    .rst(rst),
    .instrD(instrD),
    .pcPlus8D(pcPlus8D),
    .branchTaken(branchTaken),
    .resultW(resultW),
    .waW(waW),
    .regWriteW(regWriteW),
    .rd1E(rd1E),
    .rd2E(rd2E),
    .immE(immE),
    .waE(waE),
    .aluCtrlE(aluCtrlE),
    .condE(condE),
    .aluSrcE(aluSrcE),
    .regWriteE(regWriteE),
    .memWriteE(memWriteE),
    .memToRegE(memToRegE),
    .flagWriteE(flagWriteE),
    .branchE(branchE)
  );

  executeStage stageExecute (
    .clk(clk),
    .rst(rst),
    .rd1E(rd1E),
    .rd2E(rd2E),
    .immE(immE),
    .waE(waE),
    .aluCtrlE(aluCtrlE),
    .aluSrcE(aluSrcE),
    .regWriteE(regWriteE),
    .memWriteE(memWriteE),
    .memToRegE(memToRegE),
    .flagWriteE(flagWriteE),
    .branchE(branchE),
    .condE(condE),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .aluOutM(aluOutM),
    .writeDataM(writeDataM),
    .waM(waM),
    .regWriteM(regWriteM),
    .memWriteM(memWriteM),
    .memToRegM(memToRegM)
  );

  memoryStage stageMemory (
    .clk(clk),
    .rst(rst),
    .aluOutM(aluOutM),
    .writeDataM(writeDataM),
    .waM(waM),
    .regWriteM(regWriteM),
    .memWriteM(memWriteM),
    .memToRegM(memToRegM),
    .readData(readData),
    .dataAddr(dataAddr),
    .writeData(writeData),
    .memWrite(memWrite),
    .resultW(resultW),
    .waW(waW),
    .regWriteW(regWriteW)
  );

endmodule

// File: dv/armRefModel.svh
`ifndef armRefModelSvh
`define armRefModelSvh

  logic [31:0] lfsrState;
  wordT modelMem [dataWords];

  // Fibonacci form with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsrNext(logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One shift per bit handed out
  function automatic logic [31:0] randBits(int count);
    logic [31:0] bits;
    int i;
    bits = '0;
    for (i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      bits = {bits[30:0], lfsrState[0]};
    end
    return bits;
  endfunction

  function automatic wordT fillWord(int index);
    return 32'ha5a5_0000 ^ wordT'(index * 4);
  endfunction

  // NOP past the end of the program
  function automatic wordT fetchWord(wordT addr);
    if (addr[1:0] == 2'b00 && addr < wordT'(progLen * 4)) begin
      return prog[addr[10:2]];
    end
    return nopInstr;
  endfunction

  function automatic wordT encData(condT c, logic [3:0] op, logic imm, regAddrT rn,
                                   regAddrT rd, logic [7:0] op2);
    return {c, classData, imm, op, op == opCmp, rn, rd, 4'b0, op2};
  endfunction

  // Pre-indexed, offset added, no writeback
  function automatic wordT encMem(condT c, logic load, regAddrT rn, regAddrT rd,
                                  logic [11:0] offset);
    return {c, classMem, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, offset};
  endfunction

  function automatic wordT encBranch(condT c, logic [23:0] offset);
    return {c, classBranch, 1'b1, 1'b0, offset};
  endfunction

  function automatic logic condHolds(condT c, logic n, logic z, logic v);
    case (c)
      condEq: return z;
      condNe: return !z;
      condGe: return n == v;
      condLt: return n != v;
      condAl: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Runs the program one instruction at a time and queues every store
  task automatic runModel();
    wordT regs [16];
    wordT pcNow, pcNext, ins, a, b, res, addr;
    logic n, z, v, halted;
    int steps;
    int i;
    for (i = 0; i < dataWords; i++) begin
      modelMem[i] = fillWord(i);
    end
    regs = '{default: '0};
    pcNow = resetPc;
    {n, z, v, halted} = '0;
    steps = 0;
    while (!halted && steps < maxModelSteps) begin
      ins = fetchWord(pcNow);
      pcNext = pcNow + 32'd4;
      steps++;
      if (condHolds(ins[31:28], n, z, v)) begin
        case (ins[27:26])
          classData: begin
            a = regs[ins[19:16]];
            b = ins[25] ? {24'b0, ins[7:0]} : regs[ins[3:0]];
            case (ins[24:21])
              opAdd: res = a + b;
              opSub, opCmp: res = a - b;
              opAnd: res = a & b;
              opOrr: res = a | b;
              opMov: res = b;
              default: res = '0;
            endcase
            if (ins[24:21] == opCmp) begin
              n = res[31];
              z = (res == '0);
              v = (a[31] != b[31]) && (res[31] != a[31]);
            end else begin
              regs[ins[15:12]] = res;
            end
          end
          classMem: begin
            addr = regs[ins[19:16]] + {20'b0, ins[11:0]};
            if (ins[20]) begin
              regs[ins[15:12]] = modelMem[addr[11:2]];
            end else begin
              modelMem[addr[11:2]] = regs[ins[15:12]];
              expAddr.push_back(addr);
              expData.push_back(regs[ins[15:12]]);
              expPc.push_back(pcNow);
            end
          end
          classBranch: begin
            pcNext = pcNow + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
            halted = (pcNext == pcNow);
          end
          default: ;
        endcase
      end
      pcNow = pcNext;
    end
    if (!halted) begin
      errorCount++;
      $display("Reference model ran %0d steps without reaching the halt loop", steps);
    end
  endtask

`endif

// File: dv/armCoreTb.sv
`timescale 1ns/100ps

module armCoreTb
  import armPipePkg::*;
  import armIsaPkg::*;
();

  localparam int progWords = 512;
  localparam int dataWords = 1024;
  localparam int maxModelSteps = 4000;
  localparam int haltTimeout = 6000;
  // A store reaches EX/MEM while fetch is three words past it
  localparam wordT storePcLag = 32'd12;
  localparam regAddrT baseReg = 4'd12;

  logic clk;
  logic rst;
  wordT instruction, readData, pc, dataAddr, writeData;
  logic memWrite;

  wordT prog [progWords];
  int progLen;
  wordT dmem [dataWords];
  wordT expAddr [$];
  wordT expData [$];
  wordT expPc [$];
  wordT haltPc;
  int storeSlot;
  int expCount;
  int storeCount = 0;
  int errorCount = 0;
  int checkTotal = 0;

  `include "armRefModel.svh"

  armCore DUT (
    .clk(clk),
    .rst(rst),
    .instruction(instruction),
    .readData(readData),
    .pc(pc),
    .dataAddr(dataAddr),
    .writeData(writeData),
    .memWrite(memWrite)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Both memories answer just after the edge
  always @(posedge clk) begin
    #1;
    instruction = fetchWord(pc);
    readData = dmem[dataAddr[11:2]];
  end

  task automatic checkWord(string name, wordT expected, wordT actual);
    checkTotal++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkCount(string name, int expected, int actual);
    checkTotal++;
    if (actual != expected) begin
      errorCount++;
      $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // Data memory write and store comparison at mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      for (int i = 0; i < dataWords; i++) begin
        dmem[i] = fillWord(i);
      end
    end else if (memWrite) begin
      dmem[dataAddr[11:2]] = writeData;
      storeCount++;
      if (expAddr.size() == 0) begin
        errorCount++;
        $display("Store of %h to %h that the model does not predict", writeData, dataAddr);
      end else begin
        checkWord("store address", expAddr.pop_front(), dataAddr);
        checkWord("store data", expData.pop_front(), writeData);
        checkWord("store pc", expPc.pop_front() + storePcLag, pc);
      end
    end
  end

  task automatic emit(wordT word);
    prog[progLen] = word;
    progLen++;
  endtask

  task automatic emitNops(int count);
    repeat (count) emit(nopInstr);
  endtask

  // Each static store owns a word above the base
  task automatic emitStore(condT c, regAddrT rd);
    emit(encMem(c, 1'b0, baseReg, rd, 12'(storeSlot * 4)));
    storeSlot++;
  endtask

  task automatic buildProgram();
    logic [3:0] ops [5];
    condT conds [5];
    logic [7:0] a, b, c;
    logic useImm, eqCase;
    regAddrT srcA, srcB;
    int pick, slotA, loopHead, i;
    ops = '{opAdd, opSub, opAnd, opOrr, opMov};
    conds = '{condEq, condNe, condGe, condLt, condAl};
    progLen = 0;
    storeSlot = 0;
    for (i = 1; i <= 6; i++) begin
      emit(encData(condAl, opMov, 1'b1, 4'd0, regAddrT'(i), 8'(randBits(8))));
    end
    emit(encData(condAl, opMov, 1'b1, 4'd0, baseReg, 8'h80));
    emitNops(3);
    // Data processing into r7
    for (i = 0; i < 16; i++) begin
      pick = int'(randBits(3) % 5);
      srcA = regAddrT'(1 + int'(randBits(3) % 6));
      srcB = regAddrT'(1 + int'(randBits(3) % 6));
      useImm = (randBits(1) == 32'd1);
      a = 8'(randBits(8));
      emit(encData(condAl, ops[pick], useImm, srcA, 4'd7, useImm ? a : {4'b0, srcB}));
      emitNops(3);
      emitStore(condAl, 4'd7);
    end
    // Store, reload right behind it, store the copy elsewhere
    for (i = 0; i < 4; i++) begin
      slotA = storeSlot;
      emitStore(condAl, regAddrT'(1 + i));
      emit(encMem(condAl, 1'b1, baseReg, 4'd8, 12'(slotA * 4)));
      emitNops(3);
      emitStore(condAl, 4'd8);
    end
    // Compare pairs with half of them equal and r10 often negative
    for (i = 0; i < 8; i++) begin
      eqCase = (randBits(1) == 32'd1);
      a = 8'(randBits(8));
      b = eqCase ? a : 8'(randBits(8));
      c = eqCase ? 8'd0 : 8'(randBits(8));
      emit(encData(condAl, opMov, 1'b1, 4'd0, 4'd9, a));
      emit(encData(condAl, opMov, 1'b1, 4'd0, 4'd10, b));
      emit(encData(condAl, opMov, 1'b1, 4'd0, 4'd11, 8'd0));
      emitNops(3);
      emit(encData(condAl, opSub, 1'b1, 4'd10, 4'd10, c));
      emitNops(3);
      emit(encData(condAl, opCmp, 1'b0, 4'd9, 4'd0, 8'd10));
      emit(encData(condLt, opMov, 1'b0, 4'd0, 4'd11, 8'd9));
      emitStore(condEq, 4'd9);
      emitStore(condNe, 4'd10);
      emitStore(condGe, 4'd9);
      emitStore(condLt, 4'd10);
      emitStore(condAl, 4'd11);
    end
    // Forward branch over the two slots it flushes
    for (i = 0; i < 8; i++) begin
      pick = int'(randBits(3) % 5);
      srcA = regAddrT'(1 + int'(randBits(3) % 6));
      srcB = regAddrT'(1 + int'(randBits(3) % 6));
      emit(encData(condAl, opCmp, 1'b0, srcA, 4'd0, {4'b0, srcB}));
      emit(encBranch(conds[pick], 24'd1));
      emitStore(condAl, 4'd1);
      emitStore(condAl, 4'd2);
      emitStore(condAl, 4'd3);
    end
    // Counted backward loop
    emit(encData(condAl, opMov, 1'b1, 4'd0, 4'd13, 8'd3));
    emitNops(3);
    loopHead = progLen;
    emit(encData(condAl, opSub, 1'b1, 4'd13, 4'd13, 8'd1));
    emitNops(3);
    emit(encData(condAl, opCmp, 1'b1, 4'd13, 4'd0, 8'd0));
    emitStore(condAl, 4'd13);
    emit(encBranch(condNe, 24'(loopHead - progLen - 2)));
    // Keeps the halt word out of the loop's flushed slots
    emitStore(condAl, 4'd1);
    emitStore(condAl, 4'd2);
    haltPc = wordT'(progLen * 4);
    emit(encBranch(condAl, 24'hff_fffe));
  endtask

  initial begin
    int cycles;
    int haltSeen;
    rst = 1'b1;
    instruction = nopInstr;
    readData = '0;
    lfsrState = 32'hc86b_ee02;
    buildProgram();
    runModel();
    expCount = expAddr.size();

    repeat (5) @(posedge clk);
    #1;
    checkWord("reset pc", resetPc, pc);
    checkCount("reset memWrite", 0, int'(memWrite));
    rst = 1'b0;

    // Halt word fetched again once the branch-to-self has resolved
    cycles = 0;
    haltSeen = 0;
    while (haltSeen < 3 && cycles < haltTimeout) begin
      @(negedge clk);
      cycles++;
      if (pc == haltPc) begin
        haltSeen++;
      end
    end
    if (haltSeen < 3) begin
      errorCount++;
      $display("Timeout: halt loop at %h not reached in %0d cycles", haltPc, haltTimeout);
    end
    @(posedge clk);
    checkCount("store count", expCount, storeCount);

    $display("Checks %0d, errors %0d, stores %0d of %0d expected",
             checkTotal, errorCount, storeCount, expCount);
    if (errorCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+dv
rtl/armIsaPkg.sv
rtl/armPipePkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/armCore.sv
dv/armCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f project.f --top-module armCoreTb -o armCoreSim

./obj_dir/armCoreSim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi

exit 0
